/* weiDistPkg.sv */
//====================
// Weight distributor shared definitions
// Sizes of the kernel block and the packed types passed between stages
//====================
`default_nettype none

package weiDistPkg;

    //====================
    // Block geometry
    //====================
    // Kernel positions per block (3x3 kernel)
    localparam int KernelSize = 9;
    // Channels per block, one flag bit each per position
    localparam int BlockDepth = 8;
    // Bits per weight
    localparam int DataWidth  = 8;

    // Count 0..BlockDepth for one position
    localparam int CountWidth = $clog2(BlockDepth + 1);
    // Count 0..KernelSize*BlockDepth for a whole block
    localparam int TotalWidth = $clog2(KernelSize * BlockDepth + 1);

    //====================
    // Shared types
    //====================
    // One sparsity flag word, position i owns bits i*BlockDepth upward
    typedef logic [KernelSize*BlockDepth-1:0] flagWordT;

    // Nonzero counts of one block
    typedef struct packed {
        // Set bits per kernel position
        logic [KernelSize-1:0][CountWidth-1:0] posCount;
        // Sum over all positions
        logic [TotalWidth-1:0]                 total;
    } blockCountT;

    // One position's packed nonzero weights, word 0 in the low bits
    typedef logic [BlockDepth-1:0][DataWidth-1:0] weiSlotT;

    // All slots of a block, slot 0 in the low bits
    typedef weiSlotT [KernelSize-1:0] weiBlockT;

endpackage

`default_nettype wire

/* flagCount.sv */
//====================
// Flag reader and counter
// Reads one sparsity flag word per fetch and counts nonzeros per position
//====================
`default_nettype none
`timescale 1ns/100ps

module flagCount #(
    parameter int FlagAddrWidth = 10
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          fetchPls,
    input  wire                          frmDone,
    output logic                         flagEnRd,
    output logic [FlagAddrWidth-1:0]     flagAddrRd,
    input  wire  weiDistPkg::flagWordT   flagDatRd,
    output weiDistPkg::flagWordT         weiFlags,
    output weiDistPkg::blockCountT       blkCount,
    output logic                         countPls
);

    localparam int KernelSize = weiDistPkg::KernelSize;
    localparam int BlockDepth = weiDistPkg::BlockDepth;
    localparam int CountWidth = weiDistPkg::CountWidth;
    localparam int TotalWidth = weiDistPkg::TotalWidth;

    // Flag read issued last cycle, data on flagDatRd now
    logic                   rdPend;
    weiDistPkg::blockCountT nextCount;

    //====================
    // Flag buffer read
    //====================
    // Fetch is dropped in a frame-finish cycle
    assign flagEnRd = fetchPls && !frmDone;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flagAddrRd <= '0;
            rdPend     <= 1'b0;
        end else if (frmDone) begin
            flagAddrRd <= '0;
            rdPend     <= 1'b0;
        end else begin
            rdPend <= flagEnRd;
            if (flagEnRd) begin
                flagAddrRd <= flagAddrRd + 1'b1;
            end
        end
    end

    //====================
    // Population counts
    //====================
    // Per position count and block total straight from the returned word
    always_comb begin
        nextCount = '0;
        for (int i = 0; i < KernelSize; i++) begin
            for (int j = 0; j < BlockDepth; j++) begin
                nextCount.posCount[i] = nextCount.posCount[i] +
                    CountWidth'(flagDatRd[i*BlockDepth+j]);
            end
            nextCount.total = nextCount.total + TotalWidth'(nextCount.posCount[i]);
        end
    end

    // Capture flags and counts on the edge the data lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiFlags <= '0;
            blkCount <= '0;
            countPls <= 1'b0;
        end else if (frmDone) begin
            weiFlags <= '0;
            countPls <= 1'b0;
        end else begin
            countPls <= rdPend;
            if (rdPend) begin
                weiFlags <= flagDatRd;
                blkCount <= nextCount;
            end
        end
    end

    // Controller must wait for the counts before the next fetch
    fetchNoOverlap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rdPend || countPls) |-> !fetchPls
    );

endmodule

`default_nettype wire

/* weiFetch.sv */
//====================
// Weight buffer read sequencer
// Reads packed weight words until the window covers the block total
//====================
`default_nettype none
`timescale 1ns/100ps

module weiFetch #(
    parameter int PortWords    = 12,
    parameter int GbfAddrWidth = 10
) (
    input  wire                                   clk,
    input  wire                                   rst_n,
    input  wire                                   frmDone,
    input  wire                                   countPls,
    input  wire  weiDistPkg::blockCountT          blkCount,
    input  wire  [weiDistPkg::TotalWidth:0]       fillLevel,
    output logic                                  weiEnRd,
    output logic [GbfAddrWidth-1:0]               weiAddrRd,
    output logic                                  datPls,
    output logic                                  blockPls
);

    localparam int LevelWidth = weiDistPkg::TotalWidth + 1;

    // Block in progress between countPls and blockPls
    logic                  busy;
    // Weights held plus the word still in flight
    logic [LevelWidth-1:0] availLevel;
    // Total widened to the level width
    logic [LevelWidth-1:0] needLevel;

    //====================
    // Read decision
    //====================
    // datPls doubles as the in-flight flag, latency is one cycle
    assign availLevel = fillLevel + (datPls ? LevelWidth'(PortWords) : '0);
    assign needLevel  = LevelWidth'(blkCount.total);

    // One word per cycle while still short of the block total
    assign weiEnRd = busy && (availLevel < needLevel) && !frmDone;

    // Block done once nothing is in flight and the window covers it
    assign blockPls = busy && !datPls && (fillLevel >= needLevel) && !frmDone;

    //====================
    // State
    //====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (frmDone) begin
            busy <= 1'b0;
        end else if (countPls) begin
            busy <= 1'b1;
        end else if (blockPls) begin
            busy <= 1'b0;
        end
    end

    // Data valid pulse follows the enable by the buffer latency
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            datPls <= 1'b0;
        end else begin
            datPls <= weiEnRd;
        end
    end

    // Weight stream address, never rewinds inside a frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiAddrRd <= '0;
        end else if (frmDone) begin
            weiAddrRd <= '0;
        end else if (weiEnRd) begin
            weiAddrRd <= weiAddrRd + 1'b1;
        end
    end

    // A new count must not land on a block still being fetched
    countWhileBusy: assert property (
        @(posedge clk) disable iff (!rst_n)
        countPls |-> !busy
    );

endmodule

`default_nettype wire

/* weiAlign.sv */
//====================
// Weight window and slot assembly
// Buffers the weight stream, cuts per-position slots, keeps the carry-over
//====================
`default_nettype none
`timescale 1ns/100ps

module weiAlign #(
    parameter int PortWords = 12
) (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              fetchPls,
    input  wire                                              frmDone,
    input  wire                                              countPls,
    input  wire  weiDistPkg::blockCountT                     blkCount,
    input  wire                                              datPls,
    input  wire  [PortWords*weiDistPkg::DataWidth-1:0]       weiDatRd,
    input  wire                                              blockPls,
    output logic [weiDistPkg::TotalWidth:0]                  fillLevel,
    output logic                                             weiRdy,
    output weiDistPkg::weiBlockT                             weiBlock
);

    localparam int KernelSize = weiDistPkg::KernelSize;
    localparam int BlockDepth = weiDistPkg::BlockDepth;
    localparam int DataWidth  = weiDistPkg::DataWidth;
    localparam int TotalWidth = weiDistPkg::TotalWidth;
    localparam int LevelWidth = TotalWidth + 1;
    // One full block plus one word of spill
    localparam int WinSize    = KernelSize * BlockDepth + PortWords;

    // Weight window, index 0 is the oldest weight
    logic [WinSize-1:0][DataWidth-1:0]       window;
    logic [WinSize-1:0][DataWidth-1:0]       appendWin;
    // Start of each position inside the window
    logic [KernelSize-1:0][TotalWidth-1:0]   posOffset;
    logic [KernelSize-1:0][TotalWidth-1:0]   nextOffset;
    logic [TotalWidth-1:0]                   runSum;
    weiDistPkg::weiBlockT                    nextBlock;

    //====================
    // Window write
    //====================
    // Arriving word lands at the fill level, lane 0 lowest
    always_comb begin
        appendWin = window;
        for (int j = 0; j < PortWords; j++) begin
            if (int'(fillLevel) + j < WinSize) begin
                appendWin[int'(fillLevel)+j] = weiDatRd[j*DataWidth +: DataWidth];
            end
        end
    end

    // Block edge drops the consumed weights, rest becomes carry-over
    always_ff @(posedge clk) begin
        if (frmDone) begin
            window <= '0;
        end else if (blockPls) begin
            window <= window >> (DataWidth * int'(blkCount.total));
        end else if (datPls) begin
            window <= appendWin;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fillLevel <= '0;
        end else if (frmDone) begin
            fillLevel <= '0;
        end else if (blockPls) begin
            fillLevel <= fillLevel - LevelWidth'(blkCount.total);
        end else if (datPls) begin
            fillLevel <= fillLevel + LevelWidth'(PortWords);
        end
    end

    //====================
    // Position offsets
    //====================
    // Exclusive prefix sum of the counts
    always_comb begin
        runSum = '0;
        for (int i = 0; i < KernelSize; i++) begin
            nextOffset[i] = runSum;
            runSum = runSum + TotalWidth'(blkCount.posCount[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (countPls) begin
            posOffset <= nextOffset;
        end
    end

    //====================
    // Slot assembly
    //====================
    // Words past a position's count stay zero
    always_comb begin
        for (int i = 0; i < KernelSize; i++) begin
            for (int k = 0; k < BlockDepth; k++) begin
                if (k < int'(blkCount.posCount[i])) begin
                    nextBlock[i][k] = window[int'(posOffset[i])+k];
                end else begin
                    nextBlock[i][k] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiBlock <= '0;
        end else if (frmDone) begin
            weiBlock <= '0;
        end else if (blockPls) begin
            weiBlock <= nextBlock;
        end
    end

    // Ready holds until the controller asks for the next block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weiRdy <= 1'b0;
        end else if (frmDone || fetchPls) begin
            weiRdy <= 1'b0;
        end else if (blockPls) begin
            weiRdy <= 1'b1;
        end
    end

    // Fetch sequencer must never overfill the window
    fillInRange: assert property (
        @(posedge clk) disable iff (!rst_n)
        datPls |=> (fillLevel <= LevelWidth'(WinSize))
    );

endmodule

`default_nettype wire

/* weiDist.sv */
//====================
// Sparse weight distributor top
// Flag count, weight fetch and slot alignment in a three-stage chain
//====================
`default_nettype none
`timescale 1ns/100ps

module weiDist #(
    parameter int PortWords     = 12,
    parameter int GbfAddrWidth  = 10,
    parameter int FlagAddrWidth = 10
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    // Controller
    input  wire                                         fetchPls,
    input  wire                                         frmDone,
    // Processing element array
    output logic                                        weiRdy,
    output weiDistPkg::weiBlockT                        weiBlock,
    output weiDistPkg::flagWordT                        weiFlags,
    // Flag buffer
    output logic                                        flagEnRd,
    output logic [FlagAddrWidth-1:0]                    flagAddrRd,
    input  wire  weiDistPkg::flagWordT                  flagDatRd,
    // Weight buffer
    output logic                                        weiEnRd,
    output logic [GbfAddrWidth-1:0]                     weiAddrRd,
    input  wire  [PortWords*weiDistPkg::DataWidth-1:0]  weiDatRd
);

    weiDistPkg::blockCountT          blkCount;
    logic                            countPls;
    logic                            datPls;
    logic                            blockPls;
    logic [weiDistPkg::TotalWidth:0] fillLevel;

    // Stage 1, flag read and counts
    flagCount #(
        .FlagAddrWidth(FlagAddrWidth)
    ) flagCount0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetchPls  (fetchPls),
        .frmDone   (frmDone),
        .flagEnRd  (flagEnRd),
        .flagAddrRd(flagAddrRd),
        .flagDatRd (flagDatRd),
        .weiFlags  (weiFlags),
        .blkCount  (blkCount),
        .countPls  (countPls)
    );

    // Stage 2, weight word reads
    weiFetch #(
        .PortWords   (PortWords),
        .GbfAddrWidth(GbfAddrWidth)
    ) weiFetch0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .frmDone  (frmDone),
        .countPls (countPls),
        .blkCount (blkCount),
        .fillLevel(fillLevel),
        .weiEnRd  (weiEnRd),
        .weiAddrRd(weiAddrRd),
        .datPls   (datPls),
        .blockPls (blockPls)
    );

    // Stage 3, window and slots
    weiAlign #(
        .PortWords(PortWords)
    ) weiAlign0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetchPls (fetchPls),
        .frmDone  (frmDone),
        .countPls (countPls),
        .blkCount (blkCount),
        .datPls   (datPls),
        .weiDatRd (weiDatRd),
        .blockPls (blockPls),
        .fillLevel(fillLevel),
        .weiRdy   (weiRdy),
        .weiBlock (weiBlock)
    );

endmodule

`default_nettype wire

/* weiDistTb.sv */
//====================
// Weight distributor testbench
// Buffer models, a stimulus table of flag densities and a stream reference model
//====================
`default_nettype none
`timescale 1ns/100ps

module weiDistTb;

    localparam int KernelSize    = weiDistPkg::KernelSize;
    localparam int BlockDepth    = weiDistPkg::BlockDepth;
    localparam int DataWidth     = weiDistPkg::DataWidth;
    localparam int PortWords     = 12;
    localparam int GbfAddrWidth  = 10;
    localparam int FlagAddrWidth = 10;
    localparam int NumRows       = 12;
    localparam int ReadyTimeout  = 64;

    // Density modes of the stimulus table
    localparam logic [1:0] ModeRandom = 2'd0;
    localparam logic [1:0] ModeFull   = 2'd1;
    localparam logic [1:0] ModeEmpty  = 2'd2;
    localparam logic [1:0] ModeSingle = 2'd3;

    typedef struct packed {
        logic [1:0] mode;
        logic       frmBefore;
    } stimRowT;

    logic                                   clk;
    logic                                   rst_n;
    logic                                   fetchPls;
    logic                                   frmDone;
    logic                                   weiRdy;
    weiDistPkg::weiBlockT                   weiBlock;
    weiDistPkg::flagWordT                   weiFlags;
    logic                                   flagEnRd;
    logic [FlagAddrWidth-1:0]               flagAddrRd;
    weiDistPkg::flagWordT                   flagDatRd = '0;
    logic                                   weiEnRd;
    logic [GbfAddrWidth-1:0]                weiAddrRd;
    logic [PortWords*DataWidth-1:0]         weiDatRd = '0;

    weiDistPkg::flagWordT                   flagMem [0:(1<<FlagAddrWidth)-1];
    logic [PortWords*DataWidth-1:0]         weiMem [0:(1<<GbfAddrWidth)-1];
    stimRowT                                stimTable [0:NumRows-1];

    integer                                 seed = 32'hf636a470;
    int                                     errors = 0;
    int                                     checks = 0;
    int                                     testsFailed = 0;
    int                                     rowsRun = 0;
    int                                     rdCount;
    // Reference stream pointer, cleared by frmDone
    int                                     streamPtr = 0;
    bit                                     timedOut = 1'b0;
    logic [FlagAddrWidth-1:0]               expFlagAddr = '0;
    logic [GbfAddrWidth-1:0]                expWeiAddr = '0;

    weiDist #(
        .PortWords    (PortWords),
        .GbfAddrWidth (GbfAddrWidth),
        .FlagAddrWidth(FlagAddrWidth)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetchPls  (fetchPls),
        .frmDone   (frmDone),
        .weiRdy    (weiRdy),
        .weiBlock  (weiBlock),
        .weiFlags  (weiFlags),
        .flagEnRd  (flagEnRd),
        .flagAddrRd(flagAddrRd),
        .flagDatRd (flagDatRd),
        .weiEnRd   (weiEnRd),
        .weiAddrRd (weiAddrRd),
        .weiDatRd  (weiDatRd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both buffers answer one cycle after the enable
    always @(posedge clk) begin
        if (flagEnRd) begin
            flagDatRd <= flagMem[flagAddrRd];
        end
        if (weiEnRd) begin
            weiDatRd <= weiMem[weiAddrRd];
        end
    end

    //====================
    // Reference and checks
    //====================
    // Stream weight s sits at word s/PortWords, lane s%PortWords
    function automatic logic [DataWidth-1:0] streamWeight(input int s);
        return DataWidth'((s % 255) + 1);
    endfunction

    function automatic weiDistPkg::flagWordT makeFlags(input logic [1:0] mode);
        logic [95:0]           r;
        logic [BlockDepth-1:0] bits;
        int                    pos;
        weiDistPkg::flagWordT  w;
        r = {$random(seed), $random(seed), $random(seed)};
        pos = int'(r[95:64] % KernelSize);
        bits = r[BlockDepth-1:0];
        // Single position always has at least one weight
        bits[0] = 1'b1;
        w = '0;
        case (mode)
            ModeRandom: w = r[KernelSize*BlockDepth-1:0];
            ModeFull:   w = '1;
            ModeSingle: w[pos*BlockDepth +: BlockDepth] = bits;
            default:    w = '0;
        endcase
        return w;
    endfunction

    task automatic checkValue(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Waits for weiRdy and checks every weight read on the way
    task automatic waitReady(output bit ok);
        int n;
        n = 0;
        while (!weiRdy && n < ReadyTimeout) begin
            @(negedge clk);
            n++;
            if (weiEnRd) begin
                // Reads continue the frame's address sequence, no reread
                checkValue("weiAddrRd", 128'(weiAddrRd), 128'(expWeiAddr));
                expWeiAddr = expWeiAddr + 1'b1;
                rdCount++;
            end
        end
        ok = weiRdy;
    endtask

    task automatic checkBlock(input weiDistPkg::flagWordT flags);
        int                  cnt;
        int                  offs;
        weiDistPkg::weiSlotT expSlot;
        offs = 0;
        checkValue("weiFlags", 128'(weiFlags), 128'(flags));
        for (int i = 0; i < KernelSize; i++) begin
            cnt = 0;
            for (int j = 0; j < BlockDepth; j++) begin
                if (flags[i*BlockDepth+j]) begin
                    cnt++;
                end
            end
            // Packed from the low end, zero above the count
            expSlot = '0;
            for (int k = 0; k < cnt; k++) begin
                expSlot[k] = streamWeight(streamPtr + offs + k);
            end
            checkValue($sformatf("weiBlock[%0d]", i), 128'(weiBlock[i]), 128'(expSlot));
            offs += cnt;
        end
        streamPtr += offs;
    endtask

    //====================
    // Main sequence
    //====================
    initial begin
        int                   errBefore;
        bit                   ready;
        weiDistPkg::flagWordT flagWord;
        rst_n    = 1'b0;
        fetchPls = 1'b0;
        frmDone  = 1'b0;
        for (int a = 0; a < (1 << FlagAddrWidth); a++) begin
            flagMem[a] = '0;
        end
        for (int a = 0; a < (1 << GbfAddrWidth); a++) begin
            for (int j = 0; j < PortWords; j++) begin
                weiMem[a][j*DataWidth +: DataWidth] = streamWeight(a * PortWords + j);
            end
        end
        stimTable = '{
            '{ModeRandom, 1'b0}, '{ModeRandom, 1'b0}, '{ModeFull,   1'b0},
            '{ModeEmpty,  1'b0}, '{ModeRandom, 1'b0}, '{ModeSingle, 1'b0},
            '{ModeRandom, 1'b1}, '{ModeFull,   1'b0}, '{ModeSingle, 1'b0},
            '{ModeEmpty,  1'b1}, '{ModeFull,   1'b1}, '{ModeRandom, 1'b0}
        };

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checkValue("weiRdy", 128'(weiRdy), 128'(1'b0));
        checkValue("flagEnRd", 128'(flagEnRd), 128'(1'b0));
        checkValue("weiEnRd", 128'(weiEnRd), 128'(1'b0));

        for (int r = 0; r < NumRows; r++) begin
            errBefore = errors;
            flagWord = makeFlags(stimTable[r].mode);
            if (stimTable[r].frmBefore) begin
                @(posedge clk);
                frmDone <= 1'b1;
                @(posedge clk);
                frmDone <= 1'b0;
                streamPtr = 0;
                expFlagAddr = '0;
                expWeiAddr = '0;
            end
            flagMem[expFlagAddr] = flagWord;
            rdCount = 0;
            @(posedge clk);
            fetchPls <= 1'b1;
            @(negedge clk);
            checkValue("flagEnRd", 128'(flagEnRd), 128'(1'b1));
            checkValue("flagAddrRd", 128'(flagAddrRd), 128'(expFlagAddr));
            @(posedge clk);
            fetchPls <= 1'b0;
            @(negedge clk);
            // Fetch clears the previous ready
            checkValue("weiRdy", 128'(weiRdy), 128'(1'b0));
            waitReady(ready);
            if (!ready) begin
                timedOut = 1'b1;
                $display("test %0d: weiRdy did not rise within %0d cycles", r, ReadyTimeout);
                break;
            end
            checkBlock(flagWord);
            if (stimTable[r].mode == ModeEmpty) begin
                checkValue("weiEnRd count", 128'(rdCount), 128'(0));
            end
            expFlagAddr = expFlagAddr + 1'b1;
            rowsRun++;
            if (errors != errBefore) begin
                testsFailed++;
            end
            $display("test %0d mode %0d frmDone %0b reads %0d: %s", r, stimTable[r].mode,
                     stimTable[r].frmBefore, rdCount, (errors == errBefore) ? "ok" : "FAIL");
        end

        $display("tests %0d of %0d run, %0d failed, %0d checks, %0d errors",
                 rowsRun, NumRows, testsFailed, checks, errors);
        if (timedOut || errors != 0) begin
            $display("sim failed");
        end else begin
            $display("sim passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
weiDistPkg.sv
flagCount.sv
weiFetch.sv
weiAlign.sv
weiDist.sv
weiDistTb.sv

/* Makefile */
# Verilator build and run for the weight distributor testbench

VERILATOR ?= verilator
TOP       ?= weiDistTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
